//--- vic_pkg.sv
package vic_pkg;

   // chip variants, selects the raster geometry
   typedef enum logic [1:0] {
      CHIP6567R8   = 2'd0,
      CHIP6567R56A = 2'd1,
      CHIP6569     = 2'd2,
      CHIPUNUSED   = 2'd3
   } chip_t;

   // what the bus does during one phi phase
   typedef enum logic [2:0] {
      CYC_IDLE    = 3'd0,
      CYC_REFRESH = 3'd1,
      CYC_GFX     = 3'd2,
      CYC_CHAR    = 3'd3,
      CYC_CPU     = 3'd4
   } cycle_t;

   typedef struct packed {
      logic [9:0] raster_x_max;
      logic [8:0] raster_y_max;
   } chip_limits_t;

   // timing strobes shared by every block, all valid for exactly one dot4x tick
   typedef struct packed {
      logic phi;
      logic phase_start0;
      logic phase_start2;
      logic dot_tick;
   } phase_t;

   typedef struct packed {
      logic [9:0] raster_x;
      logic [8:0] raster_line;
      logic [8:0] raster_line_d;
   } raster_pos_t;

   // dot4x ticks in one phi phase
   localparam int PHASE_TICKS         = 16;
   localparam int DOTS_PER_CYCLE      = 8;
   localparam int BADLINE_FIRST       = 48;
   localparam int BADLINE_LAST        = 247;
   localparam int REFRESH_FIRST_CYCLE = 11;
   localparam int REFRESH_CYCLES      = 5;
   localparam int FETCH_FIRST_CYCLE   = 15;
   localparam int FETCH_CYCLES        = 40;

   // last pixel and last line of a frame per chip
   function automatic chip_limits_t chip_limits(input chip_t chip);
      chip_limits_t lim;
      case (chip)
         CHIP6567R8:   lim = '{raster_x_max: 10'd519, raster_y_max: 9'd262};
         CHIP6567R56A: lim = '{raster_x_max: 10'd511, raster_y_max: 9'd261};
         // 6569 and the unused code share the pal geometry
         default:      lim = '{raster_x_max: 10'd503, raster_y_max: 9'd311};
      endcase
      return lim;
   endfunction

endpackage

//--- phase_timer.sv
`timescale 1ns/100ps

module phase_timer (
   input  logic            clk_dot4x,
   input  logic            rst,
   output vic_pkg::phase_t phase,
   output logic            clk_phi
);

   localparam int PT = vic_pkg::PHASE_TICKS;

   // one full phi period, msb is the current phi level
   logic [2*PT-1:0] phi_ring;
   // one hot phase position, marker in the msb on the first tick of a phase
   logic [PT-1:0]   start_ring;
   // one hot dot position, msb marks the dot tick
   logic [3:0]      dot_ring;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         // first tick after reset opens a phi low phase
         phi_ring   <= {{PT{1'b0}}, {PT{1'b1}}};
         start_ring <= {1'b1, {(PT-1){1'b0}}};
         dot_ring   <= 4'b1000;
      end else begin
         phi_ring   <= {phi_ring[2*PT-2:0], phi_ring[2*PT-1]};
         start_ring <= {start_ring[PT-2:0], start_ring[PT-1]};
         dot_ring   <= {dot_ring[2:0], dot_ring[3]};
      end
   end

   assign clk_phi = phi_ring[2*PT-1];

   // the marker wraps to bit 0 and sits in bit 1 two ticks after the phase start
   assign phase = '{phi:          phi_ring[2*PT-1],
                    phase_start0: start_ring[PT-1],
                    phase_start2: start_ring[1],
                    dot_tick:     dot_ring[3]};

endmodule

//--- raster_counter.sv
`timescale 1ns/100ps

module raster_counter #(
   parameter int X_WIDTH = 10
) (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vic_pkg::chip_t       chip,
   input  vic_pkg::phase_t      phase,
   output vic_pkg::raster_pos_t pos,
   output logic [6:0]           cycle_num
);

   // pixels per bus cycle is a power of two, so the cycle is a plain slice
   localparam int CYC_SHIFT = $clog2(vic_pkg::DOTS_PER_CYCLE);

   vic_pkg::chip_limits_t lim;
   logic [X_WIDTH-1:0]    x_cnt;
   logic [8:0]            line;
   logic [8:0]            line_d;

   assign lim = vic_pkg::chip_limits(chip);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         x_cnt  <= '0;
         line   <= '0;
         line_d <= '0;
      end else begin
         // one pixel per dot, eight per phi period
         if (phase.dot_tick) begin
            if (x_cnt == X_WIDTH'(lim.raster_x_max)) begin
               x_cnt <= '0;
               if (line == lim.raster_y_max)
                  line <= '0;
               else
                  line <= line + 9'd1;
            end else begin
               x_cnt <= x_cnt + 1'b1;
            end
         end
         // delayed line for the interrupt compare, taken as phi goes high
         if (phase.phase_start0 && phase.phi)
            line_d <= line;
      end
   end

   // cycle spans one low and one high phase
   assign cycle_num = x_cnt[X_WIDTH-1:CYC_SHIFT];

   assign pos = '{raster_x: x_cnt, raster_line: line, raster_line_d: line_d};

endmodule

//--- cycle_sequencer.sv
`timescale 1ns/100ps

module cycle_sequencer #(
   parameter int BADLINE_FIRST = vic_pkg::BADLINE_FIRST,
   parameter int BADLINE_LAST  = vic_pkg::BADLINE_LAST
) (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vic_pkg::phase_t      phase,
   input  vic_pkg::raster_pos_t pos,
   input  logic [6:0]           cycle_num,
   input  logic                 den,
   input  logic [2:0]           yscroll,
   output vic_pkg::cycle_t      cycle_type,
   output logic                 ba_req
);

   // ba drops three cycles ahead of the first character read
   localparam int BA_FIRST   = vic_pkg::FETCH_FIRST_CYCLE - 3;
   localparam int FETCH_LAST = vic_pkg::FETCH_FIRST_CYCLE + vic_pkg::FETCH_CYCLES - 1;

   typedef enum logic [1:0] {ST_IDLE, ST_REFRESH, ST_GFX} seq_state_t;

   seq_state_t state;
   // remaining cycles of the current refresh or graphics stretch
   logic [5:0] stretch;
   logic       allow_badlines;
   logic       badline;
   logic       in_fetch;

   assign badline = allow_badlines && pos.raster_line >= 9'(BADLINE_FIRST) &&
                    pos.raster_line <= 9'(BADLINE_LAST) && pos.raster_line[2:0] == yscroll;
   assign in_fetch = cycle_num >= 7'(vic_pkg::FETCH_FIRST_CYCLE) && cycle_num <= 7'(FETCH_LAST);
   assign ba_req   = badline && cycle_num >= 7'(BA_FIRST) && cycle_num <= 7'(FETCH_LAST);

   // den anywhere on the first badline row arms badlines for the frame
   always_ff @(posedge clk_dot4x) begin
      if (rst)
         allow_badlines <= 1'b0;
      else if (pos.raster_line == 9'(BADLINE_FIRST) && den)
         allow_badlines <= 1'b1;
      else if (pos.raster_line == 9'(BADLINE_LAST + 1))
         allow_badlines <= 1'b0;
   end

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         state      <= ST_IDLE;
         stretch    <= '0;
         cycle_type <= vic_pkg::CYC_IDLE;
      end else if (phase.phase_start0) begin
         if (phase.phi) begin
            // high phase is stolen from the cpu only for character reads
            cycle_type <= (badline && in_fetch) ? vic_pkg::CYC_CHAR : vic_pkg::CYC_CPU;
         end else if (cycle_num == 7'(vic_pkg::REFRESH_FIRST_CYCLE)) begin
            state      <= ST_REFRESH;
            stretch    <= 6'(vic_pkg::REFRESH_CYCLES - 1);
            cycle_type <= vic_pkg::CYC_REFRESH;
         end else begin
            case (state)
               ST_REFRESH: begin
                  // graphics reads follow the refresh window directly
                  if (stretch == 6'd0) begin
                     state      <= ST_GFX;
                     stretch    <= 6'(vic_pkg::FETCH_CYCLES - 1);
                     cycle_type <= vic_pkg::CYC_GFX;
                  end else begin
                     stretch    <= stretch - 6'd1;
                     cycle_type <= vic_pkg::CYC_REFRESH;
                  end
               end
               ST_GFX: begin
                  if (stretch == 6'd0) begin
                     state      <= ST_IDLE;
                     cycle_type <= vic_pkg::CYC_IDLE;
                  end else begin
                     stretch    <= stretch - 6'd1;
                     cycle_type <= vic_pkg::CYC_GFX;
                  end
               end
               default: cycle_type <= vic_pkg::CYC_IDLE;
            endcase
         end
      end
   end

endmodule

//--- dram_strobes.sv
`timescale 1ns/100ps

module dram_strobes (
   input  logic            clk_dot4x,
   input  logic            rst,
   input  vic_pkg::phase_t phase,
   input  vic_pkg::cycle_t cycle_type,
   output logic            ras,
   output logic            cas,
   output logic            mux
);

   localparam int PT = vic_pkg::PHASE_TICKS;

   // msb shows on the tick after the load, low bits carry into the next phase
   // ras low from tick 5, cas low from tick 7, high again on ticks 0 to 2
   localparam logic [PT-1:0] RAS_ACCESS = 16'b1100_0000_0000_0111;
   localparam logic [PT-1:0] CAS_ACCESS = 16'b1111_0000_0000_0111;
   localparam logic [PT-1:0] NO_ACCESS  = '1;

   logic [PT-1:0] ras_sr;
   logic [PT-1:0] cas_sr;
   logic [PT-1:0] mux_sr;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ras_sr <= NO_ACCESS;
         cas_sr <= NO_ACCESS;
         mux_sr <= NO_ACCESS;
      end else if (phase.phase_start2) begin
         // cycle type is settled by now
         case (cycle_type)
            vic_pkg::CYC_IDLE, vic_pkg::CYC_CPU: begin
               ras_sr <= NO_ACCESS;
               cas_sr <= NO_ACCESS;
               mux_sr <= NO_ACCESS;
            end
            default: begin
               ras_sr <= RAS_ACCESS;
               cas_sr <= CAS_ACCESS;
               // row to column switch lines up with the ras fall
               mux_sr <= RAS_ACCESS;
            end
         endcase
      end else begin
         ras_sr <= {ras_sr[PT-2:0], 1'b0};
         cas_sr <= {cas_sr[PT-2:0], 1'b0};
         mux_sr <= {mux_sr[PT-2:0], 1'b0};
      end
   end

   assign ras = ras_sr[PT-1];
   assign cas = cas_sr[PT-1];
   assign mux = mux_sr[PT-1];

endmodule

//--- bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter #(
   parameter int BA_LEAD = 3
) (
   input  logic            clk_dot4x,
   input  logic            rst,
   input  vic_pkg::phase_t phase,
   input  logic            ba_req,
   output logic            ba,
   output logic            aec
);

   // ba history, one stage per phi high phase
   logic [BA_LEAD-1:0] ba_dly;
   // cpu may drive the bus in the coming high phase
   logic               aec_en;

   // active low bus request towards the cpu
   assign ba = ~ba_req;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         ba_dly <= '1;
         aec_en <= 1'b1;
      end else begin
         if (phase.phase_start0 && phase.phi) begin
            ba_dly[0] <= ba;
            // a rising ba releases every stage at once
            for (int i = 1; i < BA_LEAD; i++)
               ba_dly[i] <= ba_dly[i-1] | ba;
         end
         // ownership of the next high phase is fixed during the low phase
         if (phase.phase_start0 && !phase.phi)
            aec_en <= ba | ba_dly[BA_LEAD-1];
      end
   end

   // vic owns every low phase, cpu the high phases it was not robbed of
   assign aec = phase.phi & aec_en;

endmodule

//--- raster_irq.sv
`timescale 1ns/100ps

module raster_irq (
   input  logic                 clk_dot4x,
   input  logic                 rst,
   input  vic_pkg::phase_t      phase,
   input  vic_pkg::raster_pos_t pos,
   input  logic [8:0]           raster_irq_compare,
   input  logic                 erst,
   input  logic                 irst_clr,
   output logic                 irst,
   output logic                 irq
);

   // compare already matched on this line
   logic line_hit;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst     <= 1'b0;
         line_hit <= 1'b0;
      end else begin
         if (phase.phase_start2 && phase.phi) begin
            if (pos.raster_line_d == raster_irq_compare) begin
               if (!line_hit) begin
                  line_hit <= 1'b1;
                  irst     <= 1'b1;
               end
            end else begin
               line_hit <= 1'b0;
            end
         end
         // cpu acknowledge wins over a set on the same tick
         if (irst_clr)
            irst <= 1'b0;
      end
   end

   // condition latches regardless of enable, so a late erst still fires
   assign irq = irst & erst;

endmodule

//--- vic_timing.sv
`timescale 1ns/100ps

module vic_timing #(
   parameter int X_WIDTH       = 10,
   parameter int BADLINE_FIRST = vic_pkg::BADLINE_FIRST,
   parameter int BADLINE_LAST  = vic_pkg::BADLINE_LAST,
   parameter int BA_LEAD       = 3
) (
   input  logic           clk_dot4x,
   input  logic           rst,
   input  vic_pkg::chip_t chip,
   input  logic           den,
   input  logic [2:0]     yscroll,
   input  logic [8:0]     raster_irq_compare,
   input  logic           erst,
   input  logic           irst_clr,
   output logic           clk_phi,
   output logic [9:0]     raster_x,
   output logic [8:0]     raster_line,
   output logic           ras,
   output logic           cas,
   output logic           mux,
   output logic           ba,
   output logic           aec,
   output logic           irst,
   output logic           irq
);

   vic_pkg::phase_t      phase;
   vic_pkg::raster_pos_t pos;
   logic [6:0]           cycle_num;
   vic_pkg::cycle_t      cycle_type;
   logic                 ba_req;

   phase_timer u_phase_timer (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .phase     (phase),
      .clk_phi   (clk_phi)
   );

   raster_counter #(.X_WIDTH(X_WIDTH)) u_raster_counter (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .phase     (phase),
      .pos       (pos),
      .cycle_num (cycle_num)
   );

   cycle_sequencer #(
      .BADLINE_FIRST (BADLINE_FIRST),
      .BADLINE_LAST  (BADLINE_LAST)
   ) u_cycle_sequencer (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .phase      (phase),
      .pos        (pos),
      .cycle_num  (cycle_num),
      .den        (den),
      .yscroll    (yscroll),
      .cycle_type (cycle_type),
      .ba_req     (ba_req)
   );

   dram_strobes u_dram_strobes (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .phase      (phase),
      .cycle_type (cycle_type),
      .ras        (ras),
      .cas        (cas),
      .mux        (mux)
   );

   bus_arbiter #(.BA_LEAD(BA_LEAD)) u_bus_arbiter (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .phase     (phase),
      .ba_req    (ba_req),
      .ba        (ba),
      .aec       (aec)
   );

   raster_irq u_raster_irq (
      .clk_dot4x          (clk_dot4x),
      .rst                (rst),
      .phase              (phase),
      .pos                (pos),
      .raster_irq_compare (raster_irq_compare),
      .erst               (erst),
      .irst_clr           (irst_clr),
      .irst               (irst),
      .irq                (irq)
   );

   assign raster_x    = pos.raster_x;
   assign raster_line = pos.raster_line;

endmodule

//--- vic_timing_assert.sv
`timescale 1ns/100ps

module vic_timing_assert (
   input logic clk_dot4x,
   input logic rst,
   input logic clk_phi,
   input logic ras,
   input logic cas,
   input logic aec,
   input logic irst
);

   // column strobe only inside an open row
   cas_inside_ras: assert property (@(posedge clk_dot4x) disable iff (rst)
      $fell(cas) |-> !ras)
      else $error("cas fell while ras was high");

   // cpu bus ownership switches only at phi edges
   aec_moves_with_phi: assert property (@(posedge clk_dot4x) disable iff (rst)
      aec != $past(aec) |-> clk_phi != $past(clk_phi))
      else $error("aec changed in the middle of a phi phase");

   // raster compare is evaluated in the high phase only
   irst_set_in_high_phase: assert property (@(posedge clk_dot4x) disable iff (rst)
      $rose(irst) |-> clk_phi)
      else $error("irst rose while clk_phi was low");

endmodule

bind vic_timing vic_timing_assert u_timing_assert (
   .clk_dot4x (clk_dot4x),
   .rst       (rst),
   .clk_phi   (clk_phi),
   .ras       (ras),
   .cas       (cas),
   .aec       (aec),
   .irst      (irst)
);

//--- tb_vic_timing.sv
`timescale 1ns/100ps

module tb_vic_timing;

   // one table row, stimulus first and then the expected values
   typedef struct packed {
      vic_pkg::chip_t chip;
      logic           den;
      logic [2:0]     yscroll;
      logic [8:0]     irq_line;
      logic           erst;
      int             lines;
      int             line_len;
      int             frame_h;
      int             ras_bad;
      int             ras_norm;
   } row_t;

   localparam int NUM_ROWS       = 4;
   // longest line is 520 dots of 4 ticks each
   localparam int TICKS_PER_LINE = 2080;
   localparam int BA_FIRST_CYC   = 12;
   localparam int CHAR_FIRST_CYC = 15;
   localparam int CHAR_LAST_CYC  = 54;
   // strobe fall positions, ticks counted from the phase start
   localparam int RAS_FALL_TICK  = 5;
   localparam int CAS_FALL_TICK  = 7;

   logic           clk_dot4x;
   logic           rst;
   vic_pkg::chip_t chip;
   logic           den;
   logic [2:0]     yscroll;
   logic [8:0]     raster_irq_compare;
   logic           erst;
   logic           irst_clr;
   logic           clk_phi;
   logic [9:0]     raster_x;
   logic [8:0]     raster_line;
   logic           ras;
   logic           cas;
   logic           mux;
   logic           ba;
   logic           aec;
   logic           irst;
   logic           irq;

   row_t        rows [NUM_ROWS];
   logic [31:0] rng;
   int          cur;
   int          errors;
   int          checks;
   int          cycle_count;
   int          cycle_limit;
   logic        monitor_on;

   // monitor state, all sampled on the falling clock edge
   int   prev_x;
   int   prev_line;
   logic prev_phi;
   logic prev_ras;
   logic prev_cas;
   logic prev_mux;
   logic prev_irst;
   logic clr_seen;
   logic phi_seen;
   logic rise_seen;
   int   x_steps;
   int   phi_run;
   int   phi_x_steps;
   int   hcyc;
   int   hline;
   int   ras_falls;
   int   cas_falls;
   int   mux_falls;
   int   line_changes;
   int   irq_rises;

   vic_timing DUT (
      .clk_dot4x          (clk_dot4x),
      .rst                (rst),
      .chip               (chip),
      .den                (den),
      .yscroll            (yscroll),
      .raster_irq_compare (raster_irq_compare),
      .erst               (erst),
      .irst_clr           (irst_clr),
      .clk_phi            (clk_phi),
      .raster_x           (raster_x),
      .raster_line        (raster_line),
      .ras                (ras),
      .cas                (cas),
      .mux                (mux),
      .ba                 (ba),
      .aec                (aec),
      .irst               (irst),
      .irq                (irq)
   );

   initial begin
      clk_dot4x = 1'b0;
      forever #50 clk_dot4x = ~clk_dot4x;
   end

   task automatic check_value(input int actual, input int expected, input string what);
      checks++;
      if (actual != expected) begin
         errors++;
         $display("Error at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      end
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // badline rule: inside 48..247, low line bits match yscroll, den seen on line 48
   function automatic logic line_is_bad(input int line, input logic den_in, input logic [2:0] ys);
      return den_in && line >= 48 && line <= 247 && (line % 8) == int'(ys);
   endfunction

   // lines run from 0 after reset, so the compare line comes once per frame
   function automatic int count_visits(input int n, input int height, input int line);
      int hits;
      int k;
      hits = 0;
      for (k = 0; k < n; k++)
         if (k % height == line)
            hits++;
      return hits;
   endfunction

   task automatic set_row(input int r, input vic_pkg::chip_t c, input logic d, input logic e,
                          input int n, input int len, input int height);
      int span;
      span = (n < height) ? n : height;
      rows[r].chip     = c;
      rows[r].den      = d;
      rows[r].erst     = e;
      rows[r].lines    = n;
      rows[r].line_len = len;
      rows[r].frame_h  = height;
      rows[r].ras_bad  = 85;
      rows[r].ras_norm = 45;
      rng = xorshift(rng);
      rows[r].yscroll = rng[2:0];
      rng = xorshift(rng);
      // compare line picked among the lines this row reaches
      rows[r].irq_line = 9'(rng % 32'(span));
   endtask

   // full frames plus two lines cover the wrap, the last row is a short badline run
   task automatic load_table();
      int total;
      int r;
      set_row(0, vic_pkg::CHIP6567R8,   1'b1, 1'b1, 265, 520, 263);
      set_row(1, vic_pkg::CHIP6567R56A, 1'b0, 1'b1, 264, 512, 262);
      set_row(2, vic_pkg::CHIP6569,     1'b1, 1'b0, 314, 504, 312);
      set_row(3, vic_pkg::CHIPUNUSED,   1'b1, 1'b1, 60,  504, 312);
      total = 0;
      for (r = 0; r < NUM_ROWS; r++)
         total += rows[r].lines;
      cycle_limit = total * TICKS_PER_LINE + NUM_ROWS * 16 + 4096;
   endtask

   always @(posedge clk_dot4x) begin
      cycle_count++;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("Timeout: the run went past %0d clock cycles without finishing", cycle_limit);
         $display("Testbench failed");
         $finish;
      end
   end

   always @(negedge clk_dot4x) begin
      int   cyc;
      int   tick;
      int   exp_falls;
      logic exp_ba;
      logic exp_aec;
      if (!monitor_on) begin
         // held in reset, start every count afresh
         prev_x       = int'(raster_x);
         prev_line    = int'(raster_line);
         prev_phi     = clk_phi;
         prev_ras     = ras;
         prev_cas     = cas;
         prev_mux     = mux;
         prev_irst    = irst;
         clr_seen     = 1'b0;
         phi_seen     = 1'b0;
         rise_seen    = 1'b0;
         x_steps      = 0;
         phi_run      = 0;
         phi_x_steps  = 0;
         hcyc         = 0;
         hline        = 0;
         ras_falls    = 0;
         cas_falls    = 0;
         mux_falls    = 0;
         line_changes = 0;
         irq_rises    = 0;
      end else begin
         if (int'(raster_x) != prev_x) begin
            x_steps++;
            phi_x_steps++;
         end
         if (clk_phi != prev_phi) begin
            // first low phase is stretched by reset, skip it
            if (phi_seen)
               check_value(phi_run, 16, "phi phase length in ticks");
            phi_seen = 1'b1;
            phi_run  = 1;
            if (clk_phi) begin
               if (rise_seen)
                  check_value(phi_x_steps, 8, "raster_x steps per phi period");
               rise_seen   = 1'b1;
               phi_x_steps = 0;
               // owner of the high phase is fixed by the cycle at its start
               hcyc  = int'(raster_x) / 8;
               hline = int'(raster_line);
            end
         end else begin
            phi_run++;
         end
         // phi_run counts the phase start tick as one
         tick = phi_run - 1;
         if (prev_ras && !ras) begin
            ras_falls++;
            check_value(tick, RAS_FALL_TICK, "ras fall tick in phase");
         end
         if (prev_cas && !cas) begin
            cas_falls++;
            check_value(tick, CAS_FALL_TICK, "cas fall tick in phase");
         end
         if (prev_mux && !mux) begin
            mux_falls++;
            check_value(tick, RAS_FALL_TICK, "mux fall tick in phase");
         end
         cyc     = int'(raster_x) / 8;
         exp_ba  = !(line_is_bad(int'(raster_line), rows[cur].den, rows[cur].yscroll) &&
                     cyc >= BA_FIRST_CYC && cyc <= CHAR_LAST_CYC);
         exp_aec = clk_phi && !(line_is_bad(hline, rows[cur].den, rows[cur].yscroll) &&
                                hcyc >= CHAR_FIRST_CYC && hcyc <= CHAR_LAST_CYC);
         check_value(int'(ba), int'(exp_ba), "ba level");
         check_value(int'(aec), int'(exp_aec), "aec level");
         check_value(int'(irq), int'(irst && rows[cur].erst), "irq against irst and erst");
         if (irst && !prev_irst) begin
            irq_rises++;
            check_value(int'(raster_line), int'(rows[cur].irq_line), "line of irst rise");
         end
         // a clear seen on the last sample must have dropped irst
         if (clr_seen)
            check_value(int'(irst), 0, "irst after irst_clr");
         clr_seen = irst_clr;
         if (int'(raster_line) != prev_line) begin
            check_value(x_steps, rows[cur].line_len, "dot ticks per line");
            // every access drops ras, cas and mux once
            exp_falls = line_is_bad(prev_line, rows[cur].den, rows[cur].yscroll) ?
                        rows[cur].ras_bad : rows[cur].ras_norm;
            check_value(ras_falls, exp_falls, "ras falls per line");
            check_value(cas_falls, exp_falls, "cas falls per line");
            check_value(mux_falls, exp_falls, "mux falls per line");
            if (raster_line == 9'd0)
               check_value(prev_line + 1, rows[cur].frame_h, "frame height");
            else
               check_value(int'(raster_line), prev_line + 1, "raster line step");
            x_steps   = 0;
            ras_falls = 0;
            cas_falls = 0;
            mux_falls = 0;
            line_changes++;
         end
         prev_x    = int'(raster_x);
         prev_line = int'(raster_line);
         prev_phi  = clk_phi;
         prev_ras  = ras;
         prev_cas  = cas;
         prev_mux  = mux;
         prev_irst = irst;
      end
   end

   initial begin
      int r;
      rst                = 1'b1;
      chip               = vic_pkg::CHIP6567R8;
      den                = 1'b0;
      yscroll            = 3'd0;
      raster_irq_compare = 9'd0;
      erst               = 1'b0;
      irst_clr           = 1'b0;
      monitor_on         = 1'b0;
      cur                = 0;
      errors             = 0;
      checks             = 0;
      cycle_count        = 0;
      cycle_limit        = 0;
      rng                = 32'hb583_f8f2;
      load_table();
      for (r = 0; r < NUM_ROWS; r++) begin
         @(posedge clk_dot4x);
         #10;
         // every row starts from a fresh reset at line 0
         rst                = 1'b1;
         monitor_on         = 1'b0;
         irst_clr           = 1'b0;
         cur                = r;
         chip               = rows[r].chip;
         den                = rows[r].den;
         yscroll            = rows[r].yscroll;
         raster_irq_compare = rows[r].irq_line;
         erst               = rows[r].erst;
         repeat (8) @(posedge clk_dot4x);
         #10;
         rst        = 1'b0;
         monitor_on = 1'b1;
         while (line_changes < rows[r].lines) begin
            @(posedge clk_dot4x);
            #10;
            // cpu acknowledges the interrupt as soon as it sees it
            irst_clr = irst;
         end
         check_value(irq_rises, count_visits(rows[r].lines, rows[r].frame_h,
                     int'(rows[r].irq_line)), "irst rises in the run");
      end
      $display("Closing counts: %0d errors in %0d checks", errors, checks);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

//--- vic_timing.f
vic_pkg.sv
phase_timer.sv
raster_counter.sv
cycle_sequencer.sv
dram_strobes.sv
bus_arbiter.sv
raster_irq.sv
vic_timing.sv
vic_timing_assert.sv
tb_vic_timing.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

# build the testbench with assertions enabled
verilator --binary --timing --assert --top-module tb_vic_timing -f vic_timing.f -o tb_vic_timing

# run and keep the log for the result search
./obj_dir/tb_vic_timing | tee sim.log

if grep -q "Testbench failed" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi
echo "simulation finished without a failure report"
